// File: Makefile
SIM = obj_dir/Vmesh_router_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): flist.f $(wildcard hw/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --top-module mesh_router_tb -f flist.f

run: $(SIM)
	./$(SIM) | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: bench/mesh_router_tb.sv
`timescale 1ns/1ps

module mesh_router_tb;

    localparam int np          = noc_pkg::num_ports;
    localparam int fw          = noc_pkg::flit_w;
    localparam int period      = 100;
    localparam int n_dir       = 256; // every dx/dy code pair
    localparam int n_fair_each = 10;
    localparam int n_fair      = np * np * n_fair_each;
    localparam int n_bp        = 100;
    localparam int n_rand      = 200;
    localparam int total_flits = n_dir + n_fair + n_bp + n_rand;

    logic                  clk;
    logic                  rst_n;
    logic [np-1:0]         in_valid;
    logic [np-1:0][fw-1:0] in_flit;
    logic [np-1:0]         in_ready;
    logic [np-1:0]         out_valid;
    logic [np-1:0][fw-1:0] out_flit;
    logic [np-1:0]         out_ready;

    logic [fw-1:0]         tx_q [np][$];    // per-source flits waiting to be offered
    logic [fw-1:0]         exp_q [np*np][$]; // src * np + dst
    logic [12:0]           seq [np];
    int                    taken [np];
    int                    acc_count [np] = '{default: 0};
    logic [np-1:0]         stalled = '0;
    logic [np-1:0][fw-1:0] stall_flit;
    int                    fair_port = -1; // output under fairness check or -1
    int                    hist_port = -1;
    int                    fair_hist [$];
    int                    sent = 0;
    int                    received = 0;
    int                    full_seen = 0;
    int                    err_data = 0;
    int                    err_proto = 0;
    int                    err_end = 0;

    mesh_router u_mesh_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // XY rule on signed hop counts keeping sign bits as sent
    function automatic int route_ref(input logic [fw-1:0] flit, output logic [fw-1:0] fwd);
        logic [noc_pkg::xw-1:0] dx;
        logic [noc_pkg::yw-1:0] dy;
        int                     sx;
        int                     sy;
        int                     ax;
        int                     ay;
        int                     dst;
        dx  = flit[noc_pkg::dx_lsb +: noc_pkg::xw];
        dy  = flit[noc_pkg::dy_lsb +: noc_pkg::yw];
        sx  = dx[noc_pkg::xw-1] ? -int'(dx[noc_pkg::xw-2:0]) : int'(dx[noc_pkg::xw-2:0]);
        sy  = dy[noc_pkg::yw-1] ? -int'(dy[noc_pkg::yw-2:0]) : int'(dy[noc_pkg::yw-2:0]);
        ax  = (sx < 0) ? -sx : sx;
        ay  = (sy < 0) ? -sy : sy;
        fwd = flit;
        if (sx != 0) begin
            dst = (sx > 0) ? noc_pkg::port_e : noc_pkg::port_w;
            fwd[noc_pkg::dx_lsb +: noc_pkg::xw-1] = (noc_pkg::xw-1)'(ax - 1);
        end else if (sy != 0) begin
            dst = (sy > 0) ? noc_pkg::port_n : noc_pkg::port_s;
            fwd[noc_pkg::dy_lsb +: noc_pkg::yw-1] = (noc_pkg::yw-1)'(ay - 1);
        end else begin
            dst = noc_pkg::port_l;
        end
        return dst;
    endfunction

    // payload is {source, sequence}
    task automatic queue_flit(input int src, input logic [3:0] dx, input logic [3:0] dy);
        tx_q[src].push_back({dx, dy, 3'(src), seq[src]});
        seq[src] = seq[src] + 1'b1;
    endtask

    task automatic queue_toward(input int src, input int dst, input int mag);
        logic [2:0] m;
        m = 3'(mag);
        case (dst)
            noc_pkg::port_e: queue_flit(src, {1'b0, m}, 4'($urandom));
            noc_pkg::port_w: queue_flit(src, {1'b1, m}, 4'($urandom));
            noc_pkg::port_n: queue_flit(src, {1'($urandom), 3'b000}, {1'b0, m});
            noc_pkg::port_s: queue_flit(src, {1'($urandom), 3'b000}, {1'b1, m});
            default:         queue_flit(src, {1'($urandom), 3'b000}, {1'($urandom), 3'b000});
        endcase
    endtask

    task automatic drive_step(input int valid_pct, input int ready_pct);
        for (int i = 0; i < np; i++) begin
            if (acc_count[i] != taken[i]) begin // accepted on the last rising edge
                taken[i]    = acc_count[i];
                in_valid[i] = 1'b0;
            end
            if (!in_valid[i] && tx_q[i].size() > 0 && int'($urandom % 100) < valid_pct) begin
                in_flit[i]  = tx_q[i].pop_front();
                in_valid[i] = 1'b1;
            end
        end
        for (int o = 0; o < np; o++) begin
            out_ready[o] = int'($urandom % 100) < ready_pct;
        end
    endtask

    function automatic bit busy();
        bit b;
        b = (in_valid != '0) || (received < sent);
        for (int i = 0; i < np; i++) begin
            if (tx_q[i].size() > 0) begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    task automatic run_traffic(input int valid_pct, input int ready_pct);
        do begin
            @(negedge clk);
            drive_step(valid_pct, ready_pct);
        end while (busy());
    endtask

    task automatic record_input(input int src, input logic [fw-1:0] flit);
        logic [fw-1:0] fwd;
        int            dst;
        dst = route_ref(flit, fwd);
        exp_q[src * np + dst].push_back(fwd);
        sent++;
    endtask

    // each source once in any five consecutive flits
    task automatic check_window(input int o, input int src);
        logic [np-1:0] mask;
        if (hist_port != fair_port) begin
            fair_hist.delete();
            hist_port = fair_port;
        end
        fair_hist.push_back(src);
        if (fair_hist.size() > np) begin
            fair_hist.delete(0);
        end
        if (fair_hist.size() == np) begin
            mask = '0;
            foreach (fair_hist[j]) begin
                mask[fair_hist[j]] = 1'b1;
            end
            assert (mask == '1) else begin
                err_proto++;
                $display("output %0d served a source twice within five flits at %0t", o, $time);
            end
        end
    endtask

    task automatic check_output(input int o, input logic [fw-1:0] got);
        logic [fw-1:0] exp_flit;
        int            src;
        int            k;
        src = int'(got[noc_pkg::payload_w-1 -: 3]);
        received++;
        assert (src < np) else begin
            err_proto++;
            $display("output %0d delivered a flit with unknown source field %0d", o, src);
        end
        if (src < np) begin
            k = src * np + o;
            assert (exp_q[k].size() > 0) else begin
                err_proto++;
                $display("output %0d delivered a flit from input %0d that was not expected",
                         o, src);
            end
            if (exp_q[k].size() > 0) begin
                exp_flit = exp_q[k].pop_front();
                assert (got == exp_flit) else begin
                    err_data++;
                    $display("** Error at %0t: out_flit[%0d] expected %h, got %h",
                             $time, o, exp_flit, got);
                end
            end
            if (o == fair_port) begin
                check_window(o, src);
            end
        end
    endtask

    // scoreboard samples values settled since the last edge
    always @(posedge clk) begin
        if (rst_n) begin
            for (int o = 0; o < np; o++) begin
                if (stalled[o]) begin
                    assert (out_valid[o]) else begin
                        err_proto++;
                        $display("** Error at %0t: out_valid[%0d] expected 1, got 0", $time, o);
                    end
                    assert (out_flit[o] == stall_flit[o]) else begin
                        err_data++;
                        $display("** Error at %0t: out_flit[%0d] expected %h, got %h",
                                 $time, o, stall_flit[o], out_flit[o]);
                    end
                end
                stalled[o]    = out_valid[o] && !out_ready[o];
                stall_flit[o] = out_flit[o];
                if (out_valid[o] && out_ready[o]) begin
                    check_output(o, out_flit[o]);
                end
            end
            for (int i = 0; i < np; i++) begin
                if (in_valid[i] && in_ready[i]) begin
                    record_input(i, in_flit[i]);
                    acc_count[i]++;
                end
            end
            if (in_ready != '1) begin
                full_seen++;
            end
        end
    end

    initial begin
        #((total_flits * 20 + 200) * period);
        $display("timeout: run did not finish, %0d flits sent and %0d received", sent, received);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int full_mark;
        void'($urandom(63757));
        rst_n     = 1'b0;
        in_valid  = '0;
        in_flit   = '0;
        out_ready = '0;
        for (int i = 0; i < np; i++) begin
            seq[i]   = '0;
            taken[i] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (out_valid == '0) else begin
            err_end++;
            $display("** Error at %0t: out_valid expected %b, got %b", $time, 5'b0, out_valid);
        end
        assert (in_ready == '1) else begin
            err_end++;
            $display("** Error at %0t: in_ready expected %b, got %b", $time, 5'h1f, in_ready);
        end

        // all sign/magnitude pairs including negative zero
        for (int k = 0; k < n_dir; k++) begin
            queue_flit(k % np, 4'(k >> 4), 4'(k));
        end
        run_traffic(100, 100);

        for (int o = 0; o < np; o++) begin
            fair_port = o;
            for (int n = 0; n < n_fair_each; n++) begin
                for (int i = 0; i < np; i++) begin
                    queue_toward(i, o, n % 7 + 1);
                end
            end
            run_traffic(100, 100); // saturate one output
        end
        fair_port = -1;

        full_mark = full_seen;
        for (int k = 0; k < n_bp; k++) begin
            queue_toward(k % np, int'($urandom % np), int'($urandom % 7) + 1);
        end
        run_traffic(100, 20);
        assert (full_seen > full_mark) else begin
            err_end++;
            $display("no input FIFO ever filled while outputs were throttled");
        end

        for (int k = 0; k < n_rand; k++) begin
            queue_flit(int'($urandom % np), 4'($urandom), 4'($urandom));
        end
        run_traffic(60, 70);

        assert (sent == received) else begin
            err_end++;
            $display("sent %0d flits but received %0d", sent, received);
        end
        for (int k = 0; k < np * np; k++) begin
            assert (exp_q[k].size() == 0) else begin
                err_end++;
                $display("%0d flits from input %0d never left output %0d",
                         exp_q[k].size(), k / np, k % np);
            end
        end
        $display("errors: %0d data, %0d protocol, %0d end of run; flits sent %0d, received %0d",
                 err_data, err_proto, err_end, sent, received);
        if (err_data + err_proto + err_end == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/route_engine.sv
hw/rr_arbiter.sv
hw/switch_allocator.sv
hw/mesh_router.sv
bench/mesh_router_tb.sv

// File: hw/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_valid,
    input  logic [noc_pkg::flit_w-1:0] wr_flit,
    output logic                       wr_ready,
    output logic                       head_valid,
    output logic [noc_pkg::flit_w-1:0] head_flit,
    input  logic                       pop
);

    logic [noc_pkg::flit_w-1:0]     mem [noc_pkg::fifo_depth];
    logic [noc_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [noc_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [noc_pkg::fifo_cnt_w-1:0] count;
    logic                           do_wr;
    logic                           do_rd;

    assign wr_ready   = (count != noc_pkg::fifo_depth); // not full
    assign head_valid = (count != '0);
    assign head_flit  = mem[rd_ptr]; // fall-through head

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = pop && head_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == noc_pkg::fifo_ptr_w'(noc_pkg::fifo_depth - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == noc_pkg::fifo_ptr_w'(noc_pkg::fifo_depth - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            // simultaneous write and pop leaves count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // flit storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

endmodule

// File: hw/mesh_router.sv
`timescale 1ns/1ps

module mesh_router (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [noc_pkg::num_ports-1:0]                     in_valid,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] in_flit,
    output logic [noc_pkg::num_ports-1:0]                     in_ready,
    output logic [noc_pkg::num_ports-1:0]                     out_valid,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] out_flit,
    input  logic [noc_pkg::num_ports-1:0]                     out_ready
);

    logic [noc_pkg::num_ports-1:0]                         head_valid;
    logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0]    head_flit;
    logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0]    fwd_flit;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] route_req; // [input][output]
    logic [noc_pkg::num_ports-1:0][noc_pkg::xw-1:0]        dx_next;
    logic [noc_pkg::num_ports-1:0][noc_pkg::yw-1:0]        dy_next;
    logic [noc_pkg::num_ports-1:0]                         pop;

    genvar g;
    generate
        for (g = 0; g < noc_pkg::num_ports; g++) begin : g_in
            flit_fifo u_fifo (
                .clk        (clk),
                .rst_n      (rst_n),
                .wr_valid   (in_valid[g]),
                .wr_flit    (in_flit[g]),
                .wr_ready   (in_ready[g]),
                .head_valid (head_valid[g]),
                .head_flit  (head_flit[g]),
                .pop        (pop[g])
            );

            route_engine u_route (
                .delta_x      (head_flit[g][noc_pkg::dx_lsb +: noc_pkg::xw]),
                .delta_y      (head_flit[g][noc_pkg::dy_lsb +: noc_pkg::yw]),
                .delta_x_next (dx_next[g]),
                .delta_y_next (dy_next[g]),
                .dest_port    (route_req[g])
            );

            // hop counts as the next router sees them
            assign fwd_flit[g] = {dx_next[g], dy_next[g],
                                  head_flit[g][noc_pkg::payload_w-1:0]};
        end
    endgenerate

    switch_allocator u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .route_req  (route_req),
        .fwd_flit   (fwd_flit),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_flit   (out_flit),
        .out_ready  (out_ready)
    );

endmodule

// File: hw/noc_pkg.sv
package noc_pkg;

    // router ports
    localparam int num_ports  = 5;
    localparam int port_l     = 0;
    localparam int port_e     = 1;
    localparam int port_n     = 2;
    localparam int port_w     = 3;
    localparam int port_s     = 4;
    localparam int port_idx_w = 3; // holds 0..num_ports-1

    // sign-magnitude hop counts with the msb set for west/south
    localparam int xw = 4;
    localparam int yw = 4;

    // flit is {dx, dy, payload}
    localparam int payload_w = 16;
    localparam int flit_w    = xw + yw + payload_w;
    localparam int dx_lsb    = flit_w - xw;
    localparam int dy_lsb    = dx_lsb - yw;

    // input buffering
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

endpackage

// File: hw/route_engine.sv
`timescale 1ns/1ps

module route_engine (
    input  logic [noc_pkg::xw-1:0]        delta_x,
    input  logic [noc_pkg::yw-1:0]        delta_y,
    output logic [noc_pkg::xw-1:0]        delta_x_next,
    output logic [noc_pkg::yw-1:0]        delta_y_next,
    output logic [noc_pkg::num_ports-1:0] dest_port
);

    logic [noc_pkg::xw-2:0] mag_x;
    logic [noc_pkg::yw-2:0] mag_y;
    logic                   neg_x;
    logic                   neg_y;

    assign mag_x = delta_x[noc_pkg::xw-2:0];
    assign mag_y = delta_y[noc_pkg::yw-2:0];
    assign neg_x = delta_x[noc_pkg::xw-1];
    assign neg_y = delta_y[noc_pkg::yw-1];

    // dimension-ordered routing finishes x before y
    always_comb begin
        delta_x_next = delta_x;
        delta_y_next = delta_y;
        dest_port    = '0;
        if (mag_x != '0) begin
            if (!neg_x) begin // dx > 0
                dest_port[noc_pkg::port_e] = 1'b1;
            end else begin
                dest_port[noc_pkg::port_w] = 1'b1;
            end
            delta_x_next[noc_pkg::xw-2:0] = mag_x - 1'b1; // sign untouched
        end else if (mag_y != '0) begin
            if (!neg_y) begin // dy > 0
                dest_port[noc_pkg::port_n] = 1'b1;
            end else begin
                dest_port[noc_pkg::port_s] = 1'b1;
            end
            delta_y_next[noc_pkg::yw-2:0] = mag_y - 1'b1;
        end else begin
            // arrived even with negative zero
            dest_port[noc_pkg::port_l] = 1'b1;
        end
    end

endmodule

// File: hw/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [noc_pkg::num_ports-1:0] req,
    input  logic                          advance,
    output logic [noc_pkg::num_ports-1:0] grant
);

    logic [noc_pkg::port_idx_w-1:0] ptr; // highest priority index
    logic [noc_pkg::port_idx_w-1:0] grant_idx;
    logic                           found;

    // first requester at or after ptr with wraparound
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int k = 0; k < noc_pkg::num_ports; k++) begin
            idx = int'(ptr) + k;
            if (idx >= noc_pkg::num_ports) begin
                idx = idx - noc_pkg::num_ports;
            end
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = noc_pkg::port_idx_w'(idx);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance && found) begin
            ptr <= (grant_idx == noc_pkg::port_idx_w'(noc_pkg::num_ports - 1)) ?
                   '0 : grant_idx + 1'b1; // one past the winner
        end
    end

endmodule

// File: hw/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [noc_pkg::num_ports-1:0]                        head_valid,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] route_req,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0]    fwd_flit,
    output logic [noc_pkg::num_ports-1:0]                        pop,
    output logic [noc_pkg::num_ports-1:0]                        out_valid,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0]    out_flit,
    input  logic [noc_pkg::num_ports-1:0]                        out_ready
);

    // indexed [output][input]
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] out_req;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] arb_grant;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] eff_grant;
    logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0]    xbar_flit;
    logic [noc_pkg::num_ports-1:0]                         out_free;
    logic [noc_pkg::num_ports-1:0]                         out_load;

    // transpose the valid-masked requests
    always_comb begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int i = 0; i < noc_pkg::num_ports; i++) begin
                out_req[o][i] = head_valid[i] && route_req[i][o];
            end
        end
    end

    // register empty or being drained this cycle
    assign out_free = ~out_valid | out_ready;

    genvar g;
    generate
        for (g = 0; g < noc_pkg::num_ports; g++) begin : g_out
            rr_arbiter u_arb (
                .clk     (clk),
                .rst_n   (rst_n),
                .req     (out_req[g]),
                .advance (out_free[g]),
                .grant   (arb_grant[g])
            );

            assign eff_grant[g] = arb_grant[g] & {noc_pkg::num_ports{out_free[g]}};
            assign out_load[g]  = |eff_grant[g];
        end
    endgenerate

    // an input asks for one output only, so at most one grant each
    always_comb begin
        pop = '0;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            pop = pop | eff_grant[o];
        end
    end

    // crossbar
    always_comb begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            xbar_flit[o] = '0;
            for (int i = 0; i < noc_pkg::num_ports; i++) begin
                if (eff_grant[o][i]) begin
                    xbar_flit[o] = fwd_flit[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                if (out_free[o]) begin
                    out_valid[o] <= out_load[o]; // refill or go empty
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            if (out_load[o]) begin
                out_flit[o] <= xbar_flit[o];
            end
        end
    end

endmodule
